// ==== Makefile ====
TOP = exec_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f filelist.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
hw/exec_types_pkg.sv
hw/exec_bus_pkg.sv
hw/exec_alu_path.sv
hw/exec_csr_unit.sv
hw/exec_result_stage.sv
hw/exec_top.sv
testbench/exec_tb.sv

// ==== hw/exec_alu_path.sv ====
`timescale 1ns/1ps

module exec_alu_path (
  input  exec_bus_pkg::id_ex_t   id_ex_i,
  output exec_bus_pkg::alu_res_t alu_res_o
);

  // class decode
  logic is_jal;
  logic is_jalr;
  logic is_branch;
  logic is_w;
  logic is_arith;

  // alu operands and results
  logic [exec_types_pkg::XLEN-1:0]      op_a;
  logic [exec_types_pkg::XLEN-1:0]      op_b;
  logic [exec_types_pkg::XLEN-1:0]      imm_upper;
  exec_types_pkg::alu_op_e              alu_op_eff;
  logic [exec_types_pkg::SHAMT_W-1:0]   shamt;
  logic [exec_types_pkg::SHAMT_W32-1:0] shamt_w;
  logic [exec_types_pkg::XLEN-1:0]      alu_out;
  logic [exec_types_pkg::WORD_W-1:0]    w_low;
  logic [exec_types_pkg::XLEN-1:0]      result;

  // branch side
  logic                            cmp_out;
  logic [exec_types_pkg::XLEN-1:0] pc_add_imm;
  logic [exec_types_pkg::XLEN-1:0] rs1_add_imm;

  assign is_jal    = (id_ex_i.exc_op == exec_types_pkg::EXC_JAL);
  assign is_jalr   = (id_ex_i.exc_op == exec_types_pkg::EXC_JALR);
  assign is_branch = (id_ex_i.exc_op == exec_types_pkg::EXC_BRANCH);
  assign is_w      = (id_ex_i.exc_op == exec_types_pkg::EXC_OP32) |
                     (id_ex_i.exc_op == exec_types_pkg::EXC_OPIMM32);
  // only these classes take alu_op from decode
  assign is_arith  = is_w |
                     (id_ex_i.exc_op == exec_types_pkg::EXC_OP) |
                     (id_ex_i.exc_op == exec_types_pkg::EXC_OPIMM);

  // lui/auipc immediate, low 12 bits forced clear
  assign imm_upper = {id_ex_i.imm[exec_types_pkg::XLEN-1:12], 12'b0};

  // operand a
  always_comb begin
    case (id_ex_i.exc_op)
      exec_types_pkg::EXC_OP,
      exec_types_pkg::EXC_OP32,
      exec_types_pkg::EXC_BRANCH,
      exec_types_pkg::EXC_OPIMM,
      exec_types_pkg::EXC_OPIMM32,
      exec_types_pkg::EXC_LOAD,
      exec_types_pkg::EXC_STORE:   op_a = id_ex_i.rs1_data;
      exec_types_pkg::EXC_JAL,
      exec_types_pkg::EXC_JALR,
      exec_types_pkg::EXC_AUIPC:   op_a = id_ex_i.pc;
      // lui, csr and bubbles add to zero
      default:                     op_a = '0;
    endcase
  end

  // operand b
  always_comb begin
    case (id_ex_i.exc_op)
      exec_types_pkg::EXC_OP,
      exec_types_pkg::EXC_OP32,
      exec_types_pkg::EXC_BRANCH:  op_b = id_ex_i.rs2_data;
      exec_types_pkg::EXC_OPIMM,
      exec_types_pkg::EXC_OPIMM32,
      exec_types_pkg::EXC_LOAD,
      exec_types_pkg::EXC_STORE:   op_b = id_ex_i.imm;
      // old csr value goes to rd
      exec_types_pkg::EXC_CSR:     op_b = id_ex_i.csr_data;
      // link address pc + 4
      exec_types_pkg::EXC_JAL,
      exec_types_pkg::EXC_JALR:    op_b = {{(exec_types_pkg::XLEN-3){1'b0}}, 3'd4};
      exec_types_pkg::EXC_LUI,
      exec_types_pkg::EXC_AUIPC:   op_b = imm_upper;
      default:                     op_b = '0;
    endcase
  end

  // address and link classes always add
  assign alu_op_eff = is_arith ? id_ex_i.alu_op : exec_types_pkg::ALU_ADD;
  assign shamt      = op_b[exec_types_pkg::SHAMT_W-1:0];
  assign shamt_w    = op_b[exec_types_pkg::SHAMT_W32-1:0];

  // 64-bit alu
  always_comb begin
    case (alu_op_eff)
      exec_types_pkg::ALU_ADD:  alu_out = op_a + op_b;
      exec_types_pkg::ALU_SUB:  alu_out = op_a - op_b;
      exec_types_pkg::ALU_SLL:  alu_out = op_a << shamt;
      exec_types_pkg::ALU_SLT:  alu_out = {{(exec_types_pkg::XLEN-1){1'b0}},
                                           $signed(op_a) < $signed(op_b)};
      exec_types_pkg::ALU_SLTU: alu_out = {{(exec_types_pkg::XLEN-1){1'b0}}, op_a < op_b};
      exec_types_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
      exec_types_pkg::ALU_SRL:  alu_out = op_a >> shamt;
      exec_types_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
      exec_types_pkg::ALU_OR:   alu_out = op_a | op_b;
      exec_types_pkg::ALU_AND:  alu_out = op_a & op_b;
      // compare codes give no data
      default:                  alu_out = '0;
    endcase
  end

  // W forms, shifts work on the low word only
  always_comb begin
    case (alu_op_eff)
      exec_types_pkg::ALU_SLL: w_low = op_a[exec_types_pkg::WORD_W-1:0] << shamt_w;
      exec_types_pkg::ALU_SRL: w_low = op_a[exec_types_pkg::WORD_W-1:0] >> shamt_w;
      exec_types_pkg::ALU_SRA: w_low = $signed(op_a[exec_types_pkg::WORD_W-1:0]) >>> shamt_w;
      // addw/subw, low half of the full sum
      default:                 w_low = alu_out[exec_types_pkg::WORD_W-1:0];
    endcase
  end

  // sign extend from bit 31
  assign result = is_w ?
                  {{(exec_types_pkg::XLEN-exec_types_pkg::WORD_W){w_low[exec_types_pkg::WORD_W-1]}},
                   w_low} :
                  alu_out;

  // branch compare on rs1/rs2
  always_comb begin
    case (id_ex_i.alu_op)
      exec_types_pkg::ALU_BEQ:  cmp_out = (op_a == op_b);
      exec_types_pkg::ALU_BNE:  cmp_out = (op_a != op_b);
      exec_types_pkg::ALU_BLT:  cmp_out = ($signed(op_a) < $signed(op_b));
      exec_types_pkg::ALU_BGE:  cmp_out = ($signed(op_a) >= $signed(op_b));
      exec_types_pkg::ALU_BLTU: cmp_out = (op_a < op_b);
      exec_types_pkg::ALU_BGEU: cmp_out = (op_a >= op_b);
      default:                  cmp_out = 1'b0;
    endcase
  end

  // jump targets
  assign pc_add_imm  = id_ex_i.pc + id_ex_i.imm;
  assign rs1_add_imm = id_ex_i.rs1_data + id_ex_i.imm;

  always_comb begin
    alu_res_o.alu_data     = is_branch ? '0 : result;
    alu_res_o.branch_taken = (is_branch & cmp_out) | is_jal | is_jalr;
    if (is_jalr) begin
      // jalr drops bit 0
      alu_res_o.branch_target = {rs1_add_imm[exec_types_pkg::XLEN-1:1], 1'b0};
    end else if (is_jal | is_branch) begin
      alu_res_o.branch_target = pc_add_imm;
    end else begin
      alu_res_o.branch_target = '0;
    end
  end

endmodule

// ==== hw/exec_bus_pkg.sv ====
package exec_bus_pkg;

  // decoded instruction from the id/ex register
  typedef struct packed {
    logic                                    valid;
    logic [exec_types_pkg::XLEN-1:0]         pc;
    logic [exec_types_pkg::INST_W-1:0]       inst;
    logic [exec_types_pkg::REG_ADDR_W-1:0]   rd_idx;
    logic [exec_types_pkg::XLEN-1:0]         rs1_data;
    logic [exec_types_pkg::XLEN-1:0]         rs2_data;
    // already sign extended by decode
    logic [exec_types_pkg::XLEN-1:0]         imm;
    logic [exec_types_pkg::CSR_ADDR_W-1:0]   csr_addr;
    // old csr value, read in id
    logic [exec_types_pkg::XLEN-1:0]         csr_data;
    logic [exec_types_pkg::CSR_UIMM_W-1:0]   csr_uimm;
    logic                                    csr_uimm_valid;
    exec_types_pkg::exc_op_e                 exc_op;
    exec_types_pkg::alu_op_e                 alu_op;
    exec_types_pkg::csr_op_e                 csr_op;
    exec_types_pkg::mem_op_e                 mem_op;
  } id_ex_t;

  // alu path result, combinational
  typedef struct packed {
    logic [exec_types_pkg::XLEN-1:0] alu_data;
    logic                            branch_taken;
    logic [exec_types_pkg::XLEN-1:0] branch_target;
  } alu_res_t;

  // new csr value and its write enable
  typedef struct packed {
    logic [exec_types_pkg::XLEN-1:0] csr_wdata;
    logic                            csr_we;
  } csr_res_t;

  // ex/mem register contents
  typedef struct packed {
    logic                                    valid;
    logic [exec_types_pkg::XLEN-1:0]         pc;
    logic [exec_types_pkg::INST_W-1:0]       inst;
    logic [exec_types_pkg::REG_ADDR_W-1:0]   rd_idx;
    // store data
    logic [exec_types_pkg::XLEN-1:0]         rs2_data;
    exec_types_pkg::mem_op_e                 mem_op;
    // gpr result or load/store address
    logic [exec_types_pkg::XLEN-1:0]         alu_data;
    logic [exec_types_pkg::CSR_ADDR_W-1:0]   csr_addr;
    logic [exec_types_pkg::XLEN-1:0]         csr_wdata;
    logic                                    csr_we;
  } ex_mem_t;

  // new fetch address for the pc register
  typedef struct packed {
    logic                            valid;
    logic [exec_types_pkg::XLEN-1:0] target;
  } redirect_t;

endpackage

// ==== hw/exec_csr_unit.sv ====
`timescale 1ns/1ps

module exec_csr_unit (
  input  exec_bus_pkg::id_ex_t   id_ex_i,
  output exec_bus_pkg::csr_res_t csr_res_o
);

  logic                            is_csr;
  logic [exec_types_pkg::XLEN-1:0] src;
  logic                            src_zero;
  logic                            set_clr;
  logic [exec_types_pkg::XLEN-1:0] wdata;

  assign is_csr = (id_ex_i.exc_op == exec_types_pkg::EXC_CSR);

  // zimm forms use the 5-bit immediate, zero extended
  assign src = id_ex_i.csr_uimm_valid ?
               {{(exec_types_pkg::XLEN-exec_types_pkg::CSR_UIMM_W){1'b0}}, id_ex_i.csr_uimm} :
               id_ex_i.rs1_data;

  assign src_zero = (src == '0);

  // csrrs/csrrc, both read-only when source is zero
  assign set_clr = (id_ex_i.csr_op == exec_types_pkg::CSR_RS) |
                   (id_ex_i.csr_op == exec_types_pkg::CSR_RC);

  // read-modify-write value
  always_comb begin
    case (id_ex_i.csr_op)
      exec_types_pkg::CSR_RW: wdata = src;
      exec_types_pkg::CSR_RS: wdata = id_ex_i.csr_data | src;
      exec_types_pkg::CSR_RC: wdata = id_ex_i.csr_data & ~src;
      // no write, keep old value
      default:                wdata = id_ex_i.csr_data;
    endcase
  end

  assign csr_res_o.csr_wdata = wdata;
  // valid gating happens in the result stage
  assign csr_res_o.csr_we    = is_csr &
                               (id_ex_i.csr_op != exec_types_pkg::CSR_NONE) &
                               ~(set_clr & src_zero);

endmodule

// ==== hw/exec_result_stage.sv ====
`timescale 1ns/1ps

module exec_result_stage (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    stall_i,
  input  exec_bus_pkg::id_ex_t    id_ex_i,
  input  exec_bus_pkg::alu_res_t  alu_res_i,
  input  exec_bus_pkg::csr_res_t  csr_res_i,
  output exec_bus_pkg::ex_mem_t   ex_mem_o,
  output exec_bus_pkg::redirect_t redirect_o
);

  // next ex/mem record
  exec_bus_pkg::ex_mem_t ex_mem_d;
  // payload register
  exec_bus_pkg::ex_mem_t ex_mem_q;

  // control flops, these see reset
  logic valid_q;
  logic csr_we_q;
  logic redirect_valid_q;

  logic [exec_types_pkg::XLEN-1:0] redirect_target_q;
  logic                            load_en;
  logic                            redirect_d;

  // input consumed only when not stalled
  assign load_en    = ~stall_i;
  assign redirect_d = id_ex_i.valid & alu_res_i.branch_taken;

  // gather passthrough fields and both results
  always_comb begin
    ex_mem_d.valid     = id_ex_i.valid;
    ex_mem_d.pc        = id_ex_i.pc;
    ex_mem_d.inst      = id_ex_i.inst;
    ex_mem_d.rd_idx    = id_ex_i.rd_idx;
    ex_mem_d.rs2_data  = id_ex_i.rs2_data;
    ex_mem_d.mem_op    = id_ex_i.mem_op;
    ex_mem_d.alu_data  = alu_res_i.alu_data;
    ex_mem_d.csr_addr  = id_ex_i.csr_addr;
    ex_mem_d.csr_wdata = csr_res_i.csr_wdata;
    // a bubble must never write a csr
    ex_mem_d.csr_we    = id_ex_i.valid & csr_res_i.csr_we;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q          <= 1'b0;
      csr_we_q         <= 1'b0;
      redirect_valid_q <= 1'b0;
    end else begin
      // one-cycle pulse, dropped while stalled so it never repeats
      redirect_valid_q <= load_en & redirect_d;
      if (load_en) begin
        valid_q  <= ex_mem_d.valid;
        csr_we_q <= ex_mem_d.csr_we;
      end
    end
  end

  // data only, qualified by the flops above
  always_ff @(posedge clk) begin
    if (load_en) begin
      ex_mem_q          <= ex_mem_d;
      redirect_target_q <= alu_res_i.branch_target;
    end
  end

  // control fields come from the reset flops
  always_comb begin
    ex_mem_o        = ex_mem_q;
    ex_mem_o.valid  = valid_q;
    ex_mem_o.csr_we = csr_we_q;
  end

  assign redirect_o.valid  = redirect_valid_q;
  assign redirect_o.target = redirect_target_q;

endmodule

// ==== hw/exec_top.sv ====
`timescale 1ns/1ps

module exec_top (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    stall_i,
  input  exec_bus_pkg::id_ex_t    id_ex_i,
  output exec_bus_pkg::ex_mem_t   ex_mem_o,
  output exec_bus_pkg::redirect_t redirect_o
);

  // combinational results into the stage register
  exec_bus_pkg::alu_res_t alu_res;
  exec_bus_pkg::csr_res_t csr_res;

  // alu, branch compare and jump target
  exec_alu_path i_exec_alu_path (
    .id_ex_i   (id_ex_i),
    .alu_res_o (alu_res)
  );

  // csr new value, runs next to the alu
  exec_csr_unit i_exec_csr_unit (
    .id_ex_i   (id_ex_i),
    .csr_res_o (csr_res)
  );

  // ex/mem and redirect registers
  exec_result_stage i_exec_result_stage (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall_i),
    .id_ex_i    (id_ex_i),
    .alu_res_i  (alu_res),
    .csr_res_i  (csr_res),
    .ex_mem_o   (ex_mem_o),
    .redirect_o (redirect_o)
  );

endmodule

// ==== hw/exec_types_pkg.sv ====
package exec_types_pkg;

  // datapath widths, rv64i only
  localparam int unsigned XLEN       = 64;
  localparam int unsigned WORD_W     = 32;
  localparam int unsigned INST_W     = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned CSR_ADDR_W = 12;
  // zimm field of csrrwi/csrrsi/csrrci
  localparam int unsigned CSR_UIMM_W = 5;

  // shift amounts, full word and W forms
  localparam int unsigned SHAMT_W    = 6;
  localparam int unsigned SHAMT_W32  = 5;

  // opcode field widths
  localparam int unsigned EXC_OP_W   = 4;
  localparam int unsigned ALU_OP_W   = 4;
  localparam int unsigned CSR_OP_W   = 2;
  localparam int unsigned MEM_OP_W   = 4;

  // instruction class from decode
  typedef enum logic [EXC_OP_W-1:0] {
    EXC_NONE    = 4'd0,
    EXC_LUI     = 4'd1,
    EXC_AUIPC   = 4'd2,
    EXC_JAL     = 4'd3,
    EXC_JALR    = 4'd4,
    EXC_BRANCH  = 4'd5,
    EXC_LOAD    = 4'd6,
    EXC_STORE   = 4'd7,
    EXC_OPIMM   = 4'd8,
    EXC_OPIMM32 = 4'd9,
    EXC_OP      = 4'd10,
    EXC_OP32    = 4'd11,
    EXC_CSR     = 4'd12
  } exc_op_e;

  // alu function, the compare codes only matter for branches
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_BEQ  = 4'd10,
    ALU_BNE  = 4'd11,
    ALU_BLT  = 4'd12,
    ALU_BGE  = 4'd13,
    ALU_BLTU = 4'd14,
    ALU_BGEU = 4'd15
  } alu_op_e;

  // csr read-modify-write kind
  typedef enum logic [CSR_OP_W-1:0] {
    CSR_NONE = 2'd0,
    CSR_RW   = 2'd1,
    CSR_RS   = 2'd2,
    CSR_RC   = 2'd3
  } csr_op_e;

  // memory access kind, only carried through to mem
  typedef enum logic [MEM_OP_W-1:0] {
    MEM_NONE = 4'd0,
    MEM_LB   = 4'd1,
    MEM_LH   = 4'd2,
    MEM_LW   = 4'd3,
    MEM_LD   = 4'd4,
    MEM_LBU  = 4'd5,
    MEM_LHU  = 4'd6,
    MEM_LWU  = 4'd7,
    MEM_SB   = 4'd8,
    MEM_SH   = 4'd9,
    MEM_SW   = 4'd10,
    MEM_SD   = 4'd11
  } mem_op_e;

endpackage

// ==== testbench/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb;

  localparam time         CLK_PERIOD      = 100ns;
  localparam int unsigned RESET_CYCLES    = 10;
  // one cycle per issued instruction, summed over all tests
  localparam int unsigned TEST_CYCLES     = 40 + 24 + 40 + 8 + 4 + 8;
  localparam int unsigned WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 50;

  logic                    clk;
  logic                    rst_n;
  logic                    stall;
  exec_bus_pkg::id_ex_t    id_ex;
  exec_bus_pkg::ex_mem_t   ex_mem;
  exec_bus_pkg::redirect_t redirect;

  integer seed;
  int     ex_mem_errs;
  int     redirect_errs;

  exec_top i_exec_top (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .stall_i    (stall),
    .id_ex_i    (id_ex),
    .ex_mem_o   (ex_mem),
    .redirect_o (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [63:0] rnd64();
    return {$random(seed), $random(seed)};
  endfunction

  // b-type style offset, even, sign extended from bit 12
  function automatic logic [63:0] branch_offset();
    logic [12:0] off;
    off    = 13'($random(seed));
    off[0] = 1'b0;
    return {{51{off[12]}}, off};
  endfunction

  // valid instruction, side fields random
  function automatic exec_bus_pkg::id_ex_t new_instr(exec_types_pkg::exc_op_e cls,
      exec_types_pkg::alu_op_e op, logic [63:0] rs1, logic [63:0] rs2, logic [63:0] imm);
    exec_bus_pkg::id_ex_t instr;
    instr          = '0;
    instr.valid    = 1'b1;
    instr.pc       = rnd64() & ~64'h3;
    instr.inst     = $random(seed);
    instr.rd_idx   = 5'($random(seed));
    instr.rs1_data = rs1;
    instr.rs2_data = rs2;
    instr.imm      = imm;
    instr.csr_addr = 12'($random(seed));
    instr.csr_data = rnd64();
    instr.exc_op   = cls;
    instr.alu_op   = op;
    instr.csr_op   = exec_types_pkg::CSR_NONE;
    instr.mem_op   = exec_types_pkg::MEM_NONE;
    return instr;
  endfunction

  // fields that ex copies straight through
  function automatic exec_bus_pkg::ex_mem_t base_record(exec_bus_pkg::id_ex_t instr);
    exec_bus_pkg::ex_mem_t rec;
    rec          = '0;
    rec.valid    = instr.valid;
    rec.pc       = instr.pc;
    rec.inst     = instr.inst;
    rec.rd_idx   = instr.rd_idx;
    rec.rs2_data = instr.rs2_data;
    rec.mem_op   = instr.mem_op;
    rec.csr_addr = instr.csr_addr;
    return rec;
  endfunction

  // rv64i arithmetic, word selects the W forms
  function automatic logic [63:0] alu_model(exec_types_pkg::alu_op_e op, logic [63:0] a,
                                            logic [63:0] b, bit word);
    logic [31:0] lo;
    logic [63:0] r;
    if (word) begin
      case (op)
        exec_types_pkg::ALU_SUB: lo = a[31:0] - b[31:0];
        exec_types_pkg::ALU_SLL: lo = a[31:0] << b[4:0];
        exec_types_pkg::ALU_SRL: lo = a[31:0] >> b[4:0];
        exec_types_pkg::ALU_SRA: lo = $signed(a[31:0]) >>> b[4:0];
        default:                 lo = a[31:0] + b[31:0];
      endcase
      r = {{32{lo[31]}}, lo};
    end else begin
      case (op)
        exec_types_pkg::ALU_ADD:  r = a + b;
        exec_types_pkg::ALU_SUB:  r = a - b;
        exec_types_pkg::ALU_SLL:  r = a << b[5:0];
        exec_types_pkg::ALU_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        exec_types_pkg::ALU_SLTU: r = (a < b) ? 64'd1 : 64'd0;
        exec_types_pkg::ALU_XOR:  r = a ^ b;
        exec_types_pkg::ALU_SRL:  r = a >> b[5:0];
        exec_types_pkg::ALU_SRA:  r = $signed(a) >>> b[5:0];
        exec_types_pkg::ALU_OR:   r = a | b;
        default:                  r = a & b;
      endcase
    end
    return r;
  endfunction

  function automatic logic branch_model(exec_types_pkg::alu_op_e op, logic [63:0] a,
                                        logic [63:0] b);
    case (op)
      exec_types_pkg::ALU_BEQ:  return a == b;
      exec_types_pkg::ALU_BNE:  return a != b;
      exec_types_pkg::ALU_BLT:  return $signed(a) < $signed(b);
      exec_types_pkg::ALU_BGE:  return !($signed(a) < $signed(b));
      exec_types_pkg::ALU_BLTU: return a < b;
      default:                  return !(a < b);
    endcase
  endfunction

  function automatic bit field_differs(string name, logic [63:0] want, logic [63:0] got);
    if (want !== got) begin
      $display("error %s expected %h actual %h at %0t", name, want, got, $time);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic check_ex_mem(exec_bus_pkg::ex_mem_t want, exec_bus_pkg::ex_mem_t got);
    int bad;
    bad = 0;
    bad += field_differs("ex_mem_o.valid", 64'(want.valid), 64'(got.valid));
    bad += field_differs("ex_mem_o.csr_we", 64'(want.csr_we), 64'(got.csr_we));
    // payload only means something on a valid record
    if (want.valid) begin
      bad += field_differs("ex_mem_o.pc", want.pc, got.pc);
      bad += field_differs("ex_mem_o.inst", 64'(want.inst), 64'(got.inst));
      bad += field_differs("ex_mem_o.rd_idx", 64'(want.rd_idx), 64'(got.rd_idx));
      bad += field_differs("ex_mem_o.rs2_data", want.rs2_data, got.rs2_data);
      bad += field_differs("ex_mem_o.mem_op", 64'(want.mem_op), 64'(got.mem_op));
      bad += field_differs("ex_mem_o.alu_data", want.alu_data, got.alu_data);
      bad += field_differs("ex_mem_o.csr_addr", 64'(want.csr_addr), 64'(got.csr_addr));
    end
    if (want.csr_we) begin
      bad += field_differs("ex_mem_o.csr_wdata", want.csr_wdata, got.csr_wdata);
    end
    ex_mem_errs += bad;
  endtask

  task automatic check_redirect(exec_bus_pkg::redirect_t want, exec_bus_pkg::redirect_t got);
    int bad;
    bad = 0;
    bad += field_differs("redirect_o.valid", 64'(want.valid), 64'(got.valid));
    if (want.valid) begin
      bad += field_differs("redirect_o.target", want.target, got.target);
    end
    redirect_errs += bad;
  endtask

  // drive at edge + 1 ns, check one cycle later
  task automatic issue(exec_bus_pkg::id_ex_t instr, logic hold,
                       exec_bus_pkg::ex_mem_t want_em, exec_bus_pkg::redirect_t want_rd);
    id_ex = instr;
    stall = hold;
    @(posedge clk);
    #1;
    check_ex_mem(want_em, ex_mem);
    check_redirect(want_rd, redirect);
  endtask

  task automatic reset_state();
    check_ex_mem('0, ex_mem);
    check_redirect('0, redirect);
  endtask

  task automatic arith_ops();
    exec_bus_pkg::id_ex_t    instr;
    exec_bus_pkg::ex_mem_t   want;
    exec_types_pkg::alu_op_e op;
    exec_types_pkg::exc_op_e cls;
    int                      i;
    for (i = 0; i < 40; i++) begin
      op  = exec_types_pkg::alu_op_e'(4'(i % 10));
      cls = ((i / 10) % 2 == 0) ? exec_types_pkg::EXC_OP : exec_types_pkg::EXC_OPIMM;
      instr = new_instr(cls, op, rnd64(), rnd64(), rnd64());
      want  = base_record(instr);
      want.alu_data = alu_model(op, instr.rs1_data,
                                (cls == exec_types_pkg::EXC_OP) ? instr.rs2_data : instr.imm,
                                1'b0);
      issue(instr, 1'b0, want, '0);
    end
  endtask

  task automatic word_case(exec_types_pkg::alu_op_e op, logic [63:0] a, logic [63:0] b,
                           logic [63:0] result);
    exec_bus_pkg::id_ex_t  instr;
    exec_bus_pkg::ex_mem_t want;
    instr         = new_instr(exec_types_pkg::EXC_OP32, op, a, b, rnd64());
    want          = base_record(instr);
    want.alu_data = result;
    issue(instr, 1'b0, want, '0);
  endtask

  task automatic word_ops();
    exec_bus_pkg::id_ex_t    instr;
    exec_bus_pkg::ex_mem_t   want;
    exec_types_pkg::alu_op_e op;
    exec_types_pkg::exc_op_e cls;
    int                      i;
    for (i = 0; i < 20; i++) begin
      case (i % 5)
        0:       op = exec_types_pkg::ALU_ADD;
        1:       op = exec_types_pkg::ALU_SUB;
        2:       op = exec_types_pkg::ALU_SLL;
        3:       op = exec_types_pkg::ALU_SRL;
        default: op = exec_types_pkg::ALU_SRA;
      endcase
      cls = (i < 10) ? exec_types_pkg::EXC_OP32 : exec_types_pkg::EXC_OPIMM32;
      instr = new_instr(cls, op, rnd64(), rnd64(), rnd64());
      want  = base_record(instr);
      want.alu_data = alu_model(op, instr.rs1_data,
                                (cls == exec_types_pkg::EXC_OP32) ? instr.rs2_data : instr.imm,
                                1'b1);
      issue(instr, 1'b0, want, '0);
    end
    // overflow at the 32-bit boundary
    word_case(exec_types_pkg::ALU_ADD, 64'h0000_0000_7fff_ffff, 64'h1, 64'hffff_ffff_8000_0000);
    word_case(exec_types_pkg::ALU_SUB, 64'h0000_0000_8000_0000, 64'h1, 64'h0000_0000_7fff_ffff);
    word_case(exec_types_pkg::ALU_SLL, 64'h1, 64'd31, 64'hffff_ffff_8000_0000);
    // upper rs1 bits must not shift in
    word_case(exec_types_pkg::ALU_SRA, 64'h1234_5678_8000_0000, 64'd4, 64'hffff_ffff_f800_0000);
  endtask

  task automatic branch_and_jump();
    exec_bus_pkg::id_ex_t    instr;
    exec_bus_pkg::ex_mem_t   want;
    exec_bus_pkg::redirect_t rd;
    exec_types_pkg::alu_op_e op;
    exec_types_pkg::exc_op_e cls;
    logic [63:0]             rs1;
    logic [63:0]             rs2;
    int                      i;
    for (i = 0; i < 36; i++) begin
      op  = exec_types_pkg::alu_op_e'(4'(10 + i % 6));
      rs1 = rnd64();
      // equal, opposite sign, or random operands
      case ((i / 6) % 3)
        0:       rs2 = rs1;
        1:       rs2 = ~rs1;
        default: rs2 = rnd64();
      endcase
      instr     = new_instr(exec_types_pkg::EXC_BRANCH, op, rs1, rs2, branch_offset());
      want      = base_record(instr);
      rd.valid  = branch_model(op, rs1, rs2);
      rd.target = instr.pc + instr.imm;
      issue(instr, 1'b0, want, rd);
    end
    for (i = 0; i < 4; i++) begin
      cls   = (i < 2) ? exec_types_pkg::EXC_JAL : exec_types_pkg::EXC_JALR;
      instr = new_instr(cls, exec_types_pkg::ALU_ADD, rnd64(), rnd64(), branch_offset());
      want  = base_record(instr);
      want.alu_data = instr.pc + 64'd4;
      rd.valid      = 1'b1;
      if (cls == exec_types_pkg::EXC_JAL) begin
        rd.target = instr.pc + instr.imm;
      end else begin
        rd.target = (instr.rs1_data + instr.imm) & ~64'h1;
      end
      issue(instr, 1'b0, want, rd);
    end
  endtask

  task automatic csr_case(exec_types_pkg::csr_op_e op, bit use_imm, logic [4:0] uimm,
                          logic [63:0] rs1);
    exec_bus_pkg::id_ex_t  instr;
    exec_bus_pkg::ex_mem_t want;
    logic [63:0]           src;
    instr = new_instr(exec_types_pkg::EXC_CSR, exec_types_pkg::ALU_ADD, rs1, rnd64(), rnd64());
    instr.csr_op         = op;
    instr.csr_uimm       = uimm;
    instr.csr_uimm_valid = use_imm;
    src  = use_imm ? {59'd0, uimm} : rs1;
    want = base_record(instr);
    // rd gets the old csr value
    want.alu_data = instr.csr_data;
    case (op)
      exec_types_pkg::CSR_RW: want.csr_wdata = src;
      exec_types_pkg::CSR_RS: want.csr_wdata = instr.csr_data | src;
      default:                want.csr_wdata = instr.csr_data & ~src;
    endcase
    // set/clear with zero source is read only
    want.csr_we = (op == exec_types_pkg::CSR_RW) || (src != 64'd0);
    issue(instr, 1'b0, want, '0);
  endtask

  task automatic csr_ops();
    csr_case(exec_types_pkg::CSR_RW, 1'b0, 5'd0, rnd64());
    csr_case(exec_types_pkg::CSR_RS, 1'b0, 5'd7, rnd64());
    csr_case(exec_types_pkg::CSR_RC, 1'b0, 5'd0, rnd64());
    csr_case(exec_types_pkg::CSR_RW, 1'b1, 5'd21, rnd64());
    csr_case(exec_types_pkg::CSR_RS, 1'b1, 5'd9, rnd64());
    csr_case(exec_types_pkg::CSR_RC, 1'b1, 5'd31, rnd64());
    csr_case(exec_types_pkg::CSR_RS, 1'b0, 5'd3, 64'd0);
    csr_case(exec_types_pkg::CSR_RC, 1'b1, 5'd0, rnd64());
  endtask

  task automatic upper_and_mem();
    exec_bus_pkg::id_ex_t  instr;
    exec_bus_pkg::ex_mem_t want;
    instr = new_instr(exec_types_pkg::EXC_LUI, exec_types_pkg::ALU_ADD, rnd64(), rnd64(), rnd64());
    want  = base_record(instr);
    want.alu_data = instr.imm & ~64'hfff;
    issue(instr, 1'b0, want, '0);
    instr = new_instr(exec_types_pkg::EXC_AUIPC, exec_types_pkg::ALU_ADD, rnd64(), rnd64(),
                      rnd64());
    want  = base_record(instr);
    want.alu_data = instr.pc + (instr.imm & ~64'hfff);
    issue(instr, 1'b0, want, '0);
    // address = rs1 + imm, mem_op and store data pass through
    instr = new_instr(exec_types_pkg::EXC_LOAD, exec_types_pkg::ALU_ADD, rnd64(), rnd64(),
                      rnd64());
    instr.mem_op  = exec_types_pkg::MEM_LD;
    want          = base_record(instr);
    want.alu_data = instr.rs1_data + instr.imm;
    issue(instr, 1'b0, want, '0);
    instr = new_instr(exec_types_pkg::EXC_STORE, exec_types_pkg::ALU_ADD, rnd64(), rnd64(),
                      rnd64());
    instr.mem_op  = exec_types_pkg::MEM_SD;
    want          = base_record(instr);
    want.alu_data = instr.rs1_data + instr.imm;
    issue(instr, 1'b0, want, '0);
  endtask

  task automatic stall_and_bubble();
    exec_bus_pkg::id_ex_t    fill;
    exec_bus_pkg::id_ex_t    jump;
    exec_bus_pkg::id_ex_t    next;
    exec_bus_pkg::ex_mem_t   fill_em;
    exec_bus_pkg::ex_mem_t   jump_em;
    exec_bus_pkg::ex_mem_t   next_em;
    exec_bus_pkg::redirect_t jump_rd;
    fill = new_instr(exec_types_pkg::EXC_OP, exec_types_pkg::ALU_ADD, rnd64(), rnd64(), rnd64());
    fill_em = base_record(fill);
    fill_em.alu_data = fill.rs1_data + fill.rs2_data;
    issue(fill, 1'b0, fill_em, '0);
    // jump held back, register keeps the add
    jump = new_instr(exec_types_pkg::EXC_JAL, exec_types_pkg::ALU_ADD, rnd64(), rnd64(),
                     branch_offset());
    jump_em = base_record(jump);
    jump_em.alu_data = jump.pc + 64'd4;
    jump_rd.valid    = 1'b1;
    jump_rd.target   = jump.pc + jump.imm;
    issue(jump, 1'b1, fill_em, '0);
    issue(jump, 1'b1, fill_em, '0);
    issue(jump, 1'b0, jump_em, jump_rd);
    // stall right after the jump, redirect must not repeat
    next = new_instr(exec_types_pkg::EXC_OP, exec_types_pkg::ALU_XOR, rnd64(), rnd64(), rnd64());
    next_em = base_record(next);
    next_em.alu_data = next.rs1_data ^ next.rs2_data;
    issue(next, 1'b1, jump_em, '0);
    issue(next, 1'b0, next_em, '0);
    // invalid csr write, neither valid nor csr_we may show
    next        = new_instr(exec_types_pkg::EXC_CSR, exec_types_pkg::ALU_ADD, rnd64(), rnd64(),
                            rnd64());
    next.csr_op = exec_types_pkg::CSR_RW;
    next.valid  = 1'b0;
    issue(next, 1'b0, '0, '0);
    // invalid jump, no redirect
    next       = new_instr(exec_types_pkg::EXC_JAL, exec_types_pkg::ALU_ADD, rnd64(), rnd64(),
                           branch_offset());
    next.valid = 1'b0;
    issue(next, 1'b0, '0, '0);
  endtask

  initial begin
    seed          = 32'h57ed1ab4;
    ex_mem_errs   = 0;
    redirect_errs = 0;
    rst_n         = 1'b0;
    stall         = 1'b0;
    id_ex         = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_state();
    arith_ops();
    word_ops();
    branch_and_jump();
    csr_ops();
    upper_and_mem();
    stall_and_bubble();
    $display("errors: ex_mem %0d, redirect %0d", ex_mem_errs, redirect_errs);
    if (ex_mem_errs + redirect_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // run length bound
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule
